//--- verilog.f
load_pkg.sv
load_retire_if.sv
load_ctrl_fsm.sv
load_writeback.sv
load_unit.sv
tb_load_unit.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the load unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    -f verilog.f --top-module tb_load_unit -o sim_load_unit
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/sim_load_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi

//--- tb_load_unit.sv
// ----------------------------------------------------------------------
// self-checking testbench of the load unit with a cache and TLB model
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module tb_load_unit;

    localparam int unsigned SEED    = 12698;
    localparam int unsigned TIMEOUT = 50;

    // one load of the stimulus table
    typedef struct {
        load_pkg::load_op_e op;
        int                 off;
        int                 tid;
        int                 gnt_delay;
        int                 misses;
        int                 match;
        bit                 exc;
        bit                 flush;
    } row_t;

    row_t rows[$];

    logic                      clk_i;
    logic                      rst_ni;
    logic                      flush_i;
    logic                      valid_i;
    load_pkg::load_op_e        op_i;
    logic [63:0]               vaddr_i;
    logic [7:0]                be_i;
    logic [2:0]                trans_id_i;
    logic                      pop_ld_o;
    logic                      valid_o;
    logic                      ex_valid_o;
    logic [2:0]                trans_id_o;
    logic [63:0]               result_o;
    logic                      translation_req_o;
    logic                      dtlb_hit_i;
    logic [55:0]               paddr_i;
    logic                      ex_valid_i;
    logic                      page_offset_match_i;
    logic                      data_req_o;
    logic                      data_gnt_i;
    logic [11:0]               address_index_o;
    logic [43:0]               address_tag_o;
    logic [7:0]                data_be_o;
    logic [1:0]                data_size_o;
    logic                      tag_valid_o;
    logic                      kill_req_o;
    logic                      data_rvalid_i;
    logic [63:0]               data_rdata_i;

    load_unit i_dut (.*);

    always #4 clk_i = ~clk_i;

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("FAILED at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        $display("*** FAILED ***");
        $fatal(1, "value check failed");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns: %s", $time, what);
        $display("*** FAILED ***");
        $fatal(1, "wait timed out");
    endtask

    // reference realignment, shift the word down and extend by the op
    function automatic logic [63:0] expected_result(load_pkg::load_op_e op, int off,
                                                    logic [63:0] data);
        logic [63:0] sh;
        sh = data >> (8 * off);
        case (op)
            load_pkg::LW:  return {{32{sh[31]}}, sh[31:0]};
            load_pkg::LWU: return {32'b0, sh[31:0]};
            load_pkg::LH:  return {{48{sh[15]}}, sh[15:0]};
            load_pkg::LHU: return {48'b0, sh[15:0]};
            load_pkg::LB:  return {{56{sh[7]}}, sh[7:0]};
            load_pkg::LBU: return {56'b0, sh[7:0]};
            default:       return sh;
        endcase
    endfunction

    // number of bytes that a load op reads from the word
    function automatic int access_bytes(load_pkg::load_op_e op);
        case (op)
            load_pkg::LD:                return 8;
            load_pkg::LW, load_pkg::LWU: return 4;
            load_pkg::LH, load_pkg::LHU: return 2;
            default:                     return 1;
        endcase
    endfunction

    // byte enables of the bytes that the load touches
    function automatic logic [7:0] byte_mask(load_pkg::load_op_e op, int off);
        logic [15:0] ones;
        ones = (16'd1 << access_bytes(op)) - 16'd1;
        return 8'(ones << off);
    endfunction

    function automatic void add_row(load_pkg::load_op_e op, int off, int gnt_delay, int misses,
                                    int match, bit exc, bit flush);
        row_t r;
        r.op = op;
        r.off = off;
        r.tid = rows.size() % 8;
        r.gnt_delay = gnt_delay;
        r.misses = misses;
        r.match = match;
        r.exc = exc;
        r.flush = flush;
        rows.push_back(r);
    endfunction

    // every input back to its quiet value, the cache returns junk data
    task automatic drive_idle();
        flush_i = 1'b0;
        valid_i = 1'b0;
        op_i = load_pkg::LD;
        be_i = 8'hff;
        ex_valid_i = 1'b0;
        page_offset_match_i = 1'b0;
        data_gnt_i = 1'b0;
        dtlb_hit_i = 1'b0;
        data_rvalid_i = 1'b0;
        data_rdata_i = {$urandom, $urandom};
    endtask

    task automatic drive_request(input row_t r, input logic [63:0] vaddr);
        valid_i = 1'b1;
        op_i = r.op;
        vaddr_i = vaddr;
        be_i = byte_mask(r.op, r.off);
        trans_id_i = 3'(r.tid);
    endtask

    // ------------------------------------------------------------------
    // normal load, with optional grant delay, TLB misses and offset match
    // ------------------------------------------------------------------
    task automatic run_load(input row_t r);
        logic [63:0] vaddr;
        logic [63:0] data;
        logic [55:0] paddr;
        int cyc;
        int req_cycles;
        int match_left;
        int miss_left;
        int walk_cnt;
        int kills;
        int rv_delay;
        bit walking;
        bit in_walk;
        bit popped;
        bit strict;
        vaddr = {$urandom, 29'($urandom), 3'(r.off)};
        data = {$urandom, $urandom};
        rv_delay = $urandom % 4;
        paddr = {$urandom, 24'($urandom)};
        match_left = r.match;
        miss_left = r.misses;
        walk_cnt = 0;
        walking = 0;
        popped = 0;
        kills = 0;
        req_cycles = 0;
        cyc = 0;
        strict = (r.match == 0) && (r.misses == 0);
        while (!popped) begin
            if (cyc == TIMEOUT) report_timeout("pop_ld_o never rose for the load");
            @(posedge clk_i);
            #1;
            drive_idle();
            drive_request(r, vaddr);
            paddr_i = paddr;
            page_offset_match_i = (match_left > 0);
            data_gnt_i = (req_cycles >= r.gnt_delay);
            // the page walk answers with a hit after two idle cycles
            in_walk = walking;
            if (walking) begin
                dtlb_hit_i = (walk_cnt == 0);
                walking = (walk_cnt != 0);
                walk_cnt = walk_cnt - 1;
            end else begin
                dtlb_hit_i = (miss_left == 0);
            end
            @(negedge clk_i);
            if (page_offset_match_i)
                assert (data_req_o == 1'b0) else report_mismatch("data_req_o", data_req_o, 0);
            if (in_walk)
                assert (translation_req_o)
                    else report_mismatch("translation_req_o", translation_req_o, 1);
            if (strict)
                assert (data_req_o == 1'b1) else report_mismatch("data_req_o", data_req_o, 1);
            if (strict && r.gnt_delay == 0 && cyc == 0)
                assert (pop_ld_o == 1'b1) else report_mismatch("pop_ld_o", pop_ld_o, 1);
            // the cache request carries the index, size and byte enables of the load
            if (data_req_o) begin
                assert (address_index_o == vaddr[11:0])
                    else report_mismatch("address_index_o", address_index_o, vaddr[11:0]);
                assert (data_size_o == 2'($clog2(access_bytes(r.op))))
                    else report_mismatch("data_size_o", data_size_o,
                                         $clog2(access_bytes(r.op)));
                assert (data_be_o == byte_mask(r.op, r.off))
                    else report_mismatch("data_be_o", data_be_o, byte_mask(r.op, r.off));
            end
            if (match_left > 0) match_left--;
            if (data_req_o && !data_gnt_i) req_cycles++;
            if (kill_req_o && tag_valid_o) begin
                kills++;
                miss_left--;
                walking = 1;
                walk_cnt = 2;
                req_cycles = 0;
            end
            if (pop_ld_o) begin
                assert (data_req_o && data_gnt_i)
                    else report_mismatch("data_req_o && data_gnt_i", data_req_o && data_gnt_i, 1);
                popped = 1;
            end
            cyc++;
        end
        // tag cycle right after the accepted grant
        @(posedge clk_i);
        #1;
        drive_idle();
        @(negedge clk_i);
        assert (tag_valid_o == 1'b1) else report_mismatch("tag_valid_o", tag_valid_o, 1);
        assert (kill_req_o == 1'b0) else report_mismatch("kill_req_o", kill_req_o, 0);
        assert (pop_ld_o == 1'b0) else report_mismatch("pop_ld_o", pop_ld_o, 0);
        assert (kills == r.misses) else report_mismatch("kill count", kills, r.misses);
        // the tag is the physical page above the cache index
        assert (address_tag_o == paddr[55:12])
            else report_mismatch("address_tag_o", address_tag_o, paddr[55:12]);
        for (int cnt = 0; ; cnt++) begin
            if (cnt == TIMEOUT) report_timeout("no data returned for the load");
            @(posedge clk_i);
            #1;
            drive_idle();
            data_rvalid_i = (cnt == rv_delay);
            if (data_rvalid_i) data_rdata_i = data;
            @(negedge clk_i);
            if (!data_rvalid_i) begin
                assert (valid_o == 1'b0) else report_mismatch("valid_o", valid_o, 0);
            end else begin
                assert (valid_o == 1'b1) else report_mismatch("valid_o", valid_o, 1);
                assert (ex_valid_o == 1'b0) else report_mismatch("ex_valid_o", ex_valid_o, 0);
                assert (trans_id_o == 3'(r.tid))
                    else report_mismatch("trans_id_o", trans_id_o, r.tid);
                assert (result_o == expected_result(r.op, r.off, data))
                    else report_mismatch("result_o", result_o, expected_result(r.op, r.off, data));
                break;
            end
        end
    endtask

    // exception with the translation retires at once with the input id
    task automatic run_exception(input row_t r);
        @(posedge clk_i);
        #1;
        drive_idle();
        drive_request(r, {$urandom, 29'($urandom), 3'(r.off)});
        ex_valid_i = 1'b1;
        data_gnt_i = 1'b1;
        dtlb_hit_i = 1'b1;
        @(negedge clk_i);
        assert (valid_o == 1'b1) else report_mismatch("valid_o", valid_o, 1);
        assert (ex_valid_o == 1'b1) else report_mismatch("ex_valid_o", ex_valid_o, 1);
        assert (pop_ld_o == 1'b1) else report_mismatch("pop_ld_o", pop_ld_o, 1);
        assert (trans_id_o == 3'(r.tid)) else report_mismatch("trans_id_o", trans_id_o, r.tid);
        @(posedge clk_i);
        #1;
        drive_idle();
        @(negedge clk_i);
        assert (tag_valid_o == 1'b0) else report_mismatch("tag_valid_o", tag_valid_o, 0);
        assert (valid_o == 1'b0) else report_mismatch("valid_o", valid_o, 0);
    endtask

    // flush while the grant is outstanding, a stray rvalid is dropped
    task automatic run_flush(input row_t r);
        logic [63:0] vaddr;
        vaddr = {$urandom, 29'($urandom), 3'(r.off)};
        for (int cyc = 0; cyc < 2; cyc++) begin
            @(posedge clk_i);
            #1;
            drive_idle();
            drive_request(r, vaddr);
            dtlb_hit_i = 1'b1;
            flush_i = (cyc == 1);
            @(negedge clk_i);
            assert (pop_ld_o == 1'b0) else report_mismatch("pop_ld_o", pop_ld_o, 0);
        end
        @(posedge clk_i);
        #1;
        drive_idle();
        data_rvalid_i = 1'b1;
        @(negedge clk_i);
        assert (kill_req_o == 1'b1) else report_mismatch("kill_req_o", kill_req_o, 1);
        assert (tag_valid_o == 1'b1) else report_mismatch("tag_valid_o", tag_valid_o, 1);
        assert (valid_o == 1'b0) else report_mismatch("valid_o", valid_o, 0);
        repeat (3) begin
            @(posedge clk_i);
            #1;
            drive_idle();
            @(negedge clk_i);
            assert (valid_o == 1'b0) else report_mismatch("valid_o", valid_o, 0);
        end
    endtask

    initial begin
        int max_off;
        void'($urandom(SEED));
        clk_i = 1'b0;
        rst_ni = 1'b0;
        vaddr_i = '0;
        trans_id_i = '0;
        paddr_i = '0;
        drive_idle();
        // every op at every offset that stays inside the word
        for (int op = 0; op < 7; op++) begin
            max_off = (op == 0) ? 0 : (op < 3) ? 4 : (op < 5) ? 6 : 7;
            for (int off = 0; off <= max_off; off++) begin
                add_row(load_pkg::load_op_e'(op), off, 0, 0, 0, 0, 0);
            end
        end
        add_row(load_pkg::LW, 0, 3, 0, 0, 0, 0);
        add_row(load_pkg::LB, 5, 1, 0, 0, 0, 0);
        add_row(load_pkg::LD, 0, 0, 1, 0, 0, 0);
        add_row(load_pkg::LHU, 2, 1, 2, 0, 0, 0);
        add_row(load_pkg::LH, 6, 0, 0, 3, 0, 0);
        add_row(load_pkg::LWU, 4, 2, 0, 2, 0, 0);
        add_row(load_pkg::LW, 0, 0, 0, 0, 1, 0);
        add_row(load_pkg::LD, 0, 3, 0, 0, 0, 1);
        add_row(load_pkg::LB, 3, 0, 0, 0, 0, 0);

        repeat (3) @(posedge clk_i);
        assert (!(pop_ld_o | valid_o | data_req_o | tag_valid_o | kill_req_o | translation_req_o))
            else report_mismatch("outputs in reset", 1, 0);
        #1;
        rst_ni = 1'b1;

        foreach (rows[i]) begin
            if (rows[i].exc) begin
                run_exception(rows[i]);
            end else if (rows[i].flush) begin
                run_flush(rows[i]);
            end else begin
                run_load(rows[i]);
            end
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- load_unit.sv
// ----------------------------------------------------------------------
// load unit top level, request FSM and writeback joined by the retire
// interface
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module load_unit #(
    parameter int unsigned TransIdWidth = 3,
    parameter int unsigned IndexWidth   = 12,
    parameter int unsigned TagWidth     = 44
) (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             flush_i,
    // load request
    input  logic                             valid_i,
    input  load_pkg::load_op_e               op_i,
    input  logic [load_pkg::XLEN-1:0]        vaddr_i,
    input  logic [load_pkg::XLEN/8-1:0]      be_i,
    input  logic [TransIdWidth-1:0]          trans_id_i,
    output logic                             pop_ld_o,
    // load result
    output logic                             valid_o,
    output logic                             ex_valid_o,
    output logic [TransIdWidth-1:0]          trans_id_o,
    output logic [load_pkg::XLEN-1:0]        result_o,
    // MMU
    output logic                             translation_req_o,
    input  logic                             dtlb_hit_i,
    input  logic [55:0]                      paddr_i,
    input  logic                             ex_valid_i,
    // store address check
    input  logic                             page_offset_match_i,
    // data cache
    output logic                             data_req_o,
    input  logic                             data_gnt_i,
    output logic [IndexWidth-1:0]            address_index_o,
    output logic [TagWidth-1:0]              address_tag_o,
    output logic [load_pkg::XLEN/8-1:0]      data_be_o,
    output logic [1:0]                       data_size_o,
    output logic                             tag_valid_o,
    output logic                             kill_req_o,
    input  logic                             data_rvalid_i,
    input  logic [load_pkg::XLEN-1:0]        data_rdata_i
);

    load_retire_if retire_if ();

    load_ctrl_fsm #(
        .TransIdWidth (TransIdWidth),
        .IndexWidth   (IndexWidth),
        .TagWidth     (TagWidth)
    ) i_ctrl_fsm (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .valid_i             (valid_i),
        .op_i                (op_i),
        .vaddr_i             (vaddr_i),
        .be_i                (be_i),
        .pop_ld_o            (pop_ld_o),
        .page_offset_match_i (page_offset_match_i),
        .translation_req_o   (translation_req_o),
        .dtlb_hit_i          (dtlb_hit_i),
        .paddr_i             (paddr_i),
        .ex_valid_i          (ex_valid_i),
        .data_req_o          (data_req_o),
        .data_gnt_i          (data_gnt_i),
        .address_index_o     (address_index_o),
        .address_tag_o       (address_tag_o),
        .data_be_o           (data_be_o),
        .data_size_o         (data_size_o),
        .tag_valid_o         (tag_valid_o),
        .kill_req_o          (kill_req_o),
        .data_rvalid_i       (data_rvalid_i),
        .retire              (retire_if.ctrl)
    );

    // the writeback sees only the byte offset of the address
    load_writeback #(
        .TransIdWidth (TransIdWidth)
    ) i_writeback (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .op_i           (op_i),
        .vaddr_offset_i (vaddr_i[load_pkg::ALIGN_BITS-1:0]),
        .trans_id_i     (trans_id_i),
        .data_rdata_i   (data_rdata_i),
        .retire         (retire_if.wb),
        .valid_o        (valid_o),
        .ex_valid_o     (ex_valid_o),
        .trans_id_o     (trans_id_o),
        .result_o       (result_o)
    );

endmodule

//--- load_writeback.sv
// ----------------------------------------------------------------------
// load writeback with the load-info register, the realignment and the
// fast sign select of the returned data
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module load_writeback #(
    parameter int unsigned TransIdWidth = 3
) (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    // fields of the request at the input
    input  load_pkg::load_op_e                 op_i,
    input  logic [load_pkg::ALIGN_BITS-1:0]    vaddr_offset_i,
    input  logic [TransIdWidth-1:0]            trans_id_i,
    // cache read data
    input  logic [load_pkg::XLEN-1:0]          data_rdata_i,
    // strobes from the control FSM
    load_retire_if.wb                          retire,
    // result towards the core
    output logic                               valid_o,
    output logic                               ex_valid_o,
    output logic [TransIdWidth-1:0]            trans_id_o,
    output logic [load_pkg::XLEN-1:0]          result_o
);

    localparam int unsigned NumBytes = load_pkg::XLEN / 8;

    load_pkg::load_op_e                op_q;
    logic [load_pkg::ALIGN_BITS-1:0]   offset_q;
    logic [TransIdWidth-1:0]           trans_id_q;
    // pre-decoded sign information of the captured load
    logic                              signed_q;
    logic [load_pkg::ALIGN_BITS-1:0]   idx_q;

    logic [load_pkg::XLEN-1:0]         shifted_data;
    logic [NumBytes-1:0]               sign_bits;
    logic                              sign_bit;

    // ------------------------------------------------------------------
    // load-info register
    // ------------------------------------------------------------------
    // the sign byte is worked out here so that the select in the data
    // cycle runs alongside the shifter and not behind it
    always_ff @(posedge clk_i) begin
        if (retire.capture) begin
            op_q       <= op_i;
            offset_q   <= vaddr_offset_i;
            trans_id_q <= trans_id_i;
            signed_q   <= load_pkg::is_signed_op(op_i);
            idx_q      <= load_pkg::sign_byte_offset(op_i, vaddr_offset_i);
        end
    end

    // ------------------------------------------------------------------
    // realign and extend
    // ------------------------------------------------------------------
    assign shifted_data = data_rdata_i >> {offset_q, 3'b000};

    // top bit of every byte lane, one of them is the sign
    for (genvar i = 0; i < NumBytes; i++) begin : g_sign_bits
        assign sign_bits[i] = data_rdata_i[i*8+7];
    end

    // unsigned loads pull the sign to zero
    assign sign_bit = signed_q & sign_bits[idx_q];

    always_comb begin
        case (op_q)
            load_pkg::LW, load_pkg::LWU: begin
                result_o = {{(load_pkg::XLEN-32){sign_bit}}, shifted_data[31:0]};
            end
            load_pkg::LH, load_pkg::LHU: begin
                result_o = {{(load_pkg::XLEN-16){sign_bit}}, shifted_data[15:0]};
            end
            load_pkg::LB, load_pkg::LBU: begin
                result_o = {{(load_pkg::XLEN-8){sign_bit}}, shifted_data[7:0]};
            end
            default: begin
                result_o = shifted_data;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // retire
    // ------------------------------------------------------------------
    assign valid_o    = retire.retire_data | retire.retire_ex_tag | retire.retire_ex_new;
    assign ex_valid_o = retire.retire_ex_tag | retire.retire_ex_new;
    // an exception at the input was never captured and carries its own id
    assign trans_id_o = retire.retire_ex_new ? trans_id_i : trans_id_q;

    // a data result never comes from an offset that crosses the word
    a_offset_word: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o && !ex_valid_o && (op_q inside {load_pkg::LW, load_pkg::LWU}) |->
            offset_q < 5);
    a_offset_half: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o && !ex_valid_o && (op_q inside {load_pkg::LH, load_pkg::LHU}) |->
            offset_q < 7);
    a_offset_double: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o && !ex_valid_o && (op_q == load_pkg::LD) |-> offset_q == 0);

endmodule

//--- load_ctrl_fsm.sv
// ----------------------------------------------------------------------
// load request FSM, drives the translation request, the cache request,
// the physical tag and the kill, and decides when returned data retires
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module load_ctrl_fsm #(
    parameter int unsigned TransIdWidth = 3,
    parameter int unsigned IndexWidth   = 12,
    parameter int unsigned TagWidth     = 44
) (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             flush_i,
    // request from the issue side
    input  logic                             valid_i,
    input  load_pkg::load_op_e               op_i,
    input  logic [load_pkg::XLEN-1:0]        vaddr_i,
    input  logic [load_pkg::XLEN/8-1:0]      be_i,
    output logic                             pop_ld_o,
    // store address check
    input  logic                             page_offset_match_i,
    // MMU
    output logic                             translation_req_o,
    input  logic                             dtlb_hit_i,
    input  logic [55:0]                      paddr_i,
    input  logic                             ex_valid_i,
    // data cache
    output logic                             data_req_o,
    input  logic                             data_gnt_i,
    output logic [IndexWidth-1:0]            address_index_o,
    output logic [TagWidth-1:0]              address_tag_o,
    output logic [load_pkg::XLEN/8-1:0]      data_be_o,
    output logic [1:0]                       data_size_o,
    output logic                             tag_valid_o,
    output logic                             kill_req_o,
    input  logic                             data_rvalid_i,
    // strobes to the writeback
    load_retire_if.ctrl                      retire
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GNT,
        SEND_TAG,
        WAIT_PAGE_OFFSET,
        ABORT_TRANSACTION,
        WAIT_TRANSLATION,
        WAIT_FLUSH
    } state_e;

    state_e state_d, state_q;
    // a new request may start from idle or from the tag cycle of the last one
    logic   start_req;
    // data that arrives while a flush, a kill or a pending retranslation is active is dropped
    logic   rvalid_ok;

    // the tag and the index together make up the physical address
    if (TransIdWidth == 0 || IndexWidth + TagWidth != 56) begin : g_width_check
        $error("load_ctrl_fsm needs a trans_id and index plus tag equal to the paddr width");
    end

    // the index comes straight from the virtual address, the tag from the
    // translation that is present in the cycle after the grant
    assign address_index_o = vaddr_i[IndexWidth-1:0];
    assign address_tag_o   = paddr_i[TagWidth+IndexWidth-1:IndexWidth];
    assign data_be_o       = be_i;
    assign data_size_o     = load_pkg::transfer_size(op_i);

    // ------------------------------------------------------------------
    // request control
    // ------------------------------------------------------------------
    always_comb begin
        state_d           = state_q;
        start_req         = 1'b0;
        translation_req_o = 1'b0;
        data_req_o        = 1'b0;
        tag_valid_o       = 1'b0;
        kill_req_o        = 1'b0;
        pop_ld_o          = 1'b0;

        case (state_q)
            IDLE: begin
                start_req = valid_i;
            end
            // the tag is valid for sure, and the next load may already ask
            SEND_TAG: begin
                tag_valid_o = 1'b1;
                state_d     = IDLE;
                start_req   = valid_i;
                // an exception in the tag cycle cancels the request at the cache
                if (ex_valid_i) begin
                    kill_req_o = 1'b1;
                end
            end
            // stall until the pending store no longer aliases the page offset
            WAIT_PAGE_OFFSET: begin
                if (!page_offset_match_i) begin
                    state_d = WAIT_GNT;
                end
            end
            // free the cache arbiter so that the page table walk can proceed
            ABORT_TRANSACTION: begin
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = WAIT_TRANSLATION;
            end
            WAIT_TRANSLATION: begin
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = WAIT_GNT;
                end
            end
            // hold both requests until the cache grants
            WAIT_GNT: begin
                translation_req_o = 1'b1;
                data_req_o        = 1'b1;
            end
            // kill whatever request might still be outstanding
            WAIT_FLUSH: begin
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        // translation starts at once even if the page offset still matches
        if (start_req) begin
            translation_req_o = 1'b1;
            if (page_offset_match_i) begin
                state_d = WAIT_PAGE_OFFSET;
            end else begin
                data_req_o = 1'b1;
                if (!data_gnt_i) begin
                    state_d = WAIT_GNT;
                end
            end
        end

        // an accepted grant sends the tag next cycle, or aborts on a TLB miss
        if (data_req_o && data_gnt_i) begin
            if (dtlb_hit_i) begin
                state_d  = SEND_TAG;
                pop_ld_o = 1'b1;
            end else begin
                state_d = ABORT_TRANSACTION;
            end
        end

        // an exception ends the request, the pop waits if data retires now
        if (valid_i && ex_valid_i) begin
            state_d  = IDLE;
            pop_ld_o = !data_rvalid_i;
        end

        if (flush_i) begin
            state_d = WAIT_FLUSH;
        end
    end

    // ------------------------------------------------------------------
    // retire decision
    // ------------------------------------------------------------------
    assign rvalid_ok = data_rvalid_i && (state_q != WAIT_FLUSH) && (state_q != WAIT_TRANSLATION);

    // an excepting request keeps its payload out of the load-info register
    assign retire.capture       = pop_ld_o && !ex_valid_i;
    assign retire.retire_data   = rvalid_ok && !kill_req_o;
    assign retire.retire_ex_tag = rvalid_ok && ex_valid_i && (state_q == SEND_TAG);
    // rvalid has priority, so the input exception waits a cycle when data returns
    assign retire.retire_ex_new = valid_i && ex_valid_i && !data_rvalid_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // a pop needs the request still at the input, and either the cache took it
    // with a valid translation or the request leaves with an exception
    a_pop_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_ld_o |-> valid_i && ((data_req_o && data_gnt_i && dtlb_hit_i) || ex_valid_i));

    // a popped load without exception or flush presents its tag next cycle
    a_tag_after_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_ld_o && !ex_valid_i && !flush_i |=> tag_valid_o && !kill_req_o || ex_valid_i);

endmodule

//--- load_retire_if.sv
// ----------------------------------------------------------------------
// retire strobes from the load control FSM to the writeback stage
// ----------------------------------------------------------------------
`timescale 1ns/10ps

interface load_retire_if;

    // latch op, offset and trans_id of the request at the input
    logic capture;
    // the returned cache data is a valid result in this cycle
    logic retire_data;
    // an exception retires for the load that sits in its tag cycle
    logic retire_ex_tag;
    // an exception retires for the request at the input, with its trans_id
    logic retire_ex_new;

    modport ctrl (
        output capture,
        output retire_data,
        output retire_ex_tag,
        output retire_ex_new
    );

    modport wb (
        input capture,
        input retire_data,
        input retire_ex_tag,
        input retire_ex_new
    );

endinterface

//--- load_pkg.sv
// ----------------------------------------------------------------------
// load unit package with the data widths, the load operation encoding
// and the helpers that decode an operation for the cache and the sign
// ----------------------------------------------------------------------
package load_pkg;

    // one data word of a 64-bit core
    localparam int unsigned XLEN = 64;
    // byte offset inside a data word
    localparam int unsigned ALIGN_BITS = 3;

    typedef enum logic [2:0] {
        LD,
        LW,
        LWU,
        LH,
        LHU,
        LB,
        LBU
    } load_op_e;

    // size code of the cache request, log2 of the number of bytes
    function automatic logic [1:0] transfer_size(load_op_e op);
        case (op)
            LD:       return 2'd3;
            LW, LWU:  return 2'd2;
            LH, LHU:  return 2'd1;
            default:  return 2'd0;
        endcase
    endfunction

    // true for the loads whose result is sign-extended
    function automatic logic is_signed_op(load_op_e op);
        return op inside {LW, LH, LB};
    endfunction

    // byte index that holds the sign bit of the loaded value
    // the index wraps for offsets that the op does not allow
    function automatic logic [ALIGN_BITS-1:0] sign_byte_offset(load_op_e op,
                                                               logic [ALIGN_BITS-1:0] offset);
        case (op)
            LW, LWU:  return offset + ALIGN_BITS'(3);
            LH, LHU:  return offset + ALIGN_BITS'(1);
            default:  return offset;
        endcase
    endfunction

endpackage
